/* sim.f */
+incdir+tests
src/cpu_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/cpu_top.sv
tests/tb_cpu.sv

/* src/cpu_pkg.sv */
// shared widths, encodings and pipeline register layouts
// only add, sub, and, or, slt, addi, lw and sw are encoded
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;   // second alu input is the immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd_dst;
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rd_dst;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;   // only for rd not zero
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_event_t;

    typedef struct packed {
        logic            valid;
        logic [7:0]      addr;    // word index
        logic [XLEN-1:0] word;
    } prog_load_t;

endpackage

`default_nettype wire

/* src/cpu_top.sv */
// five-stage pipeline, program loaded through prog while run is low
// retire strobes once per register write with rd not zero, in program order
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                run,
    input  cpu_pkg::prog_load_t prog,
    output cpu_pkg::wb_event_t  retire
);

    cpu_pkg::if_id_t    if_id;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::wb_event_t wb;
    cpu_pkg::fwd_sel_e  fwd_a;
    cpu_pkg::fwd_sel_e  fwd_b;
    logic               stall;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .stall     (stall),
        .prog      (prog),
        .if_id     (if_id)
    );

    decode_stage i_decode (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .if_id     (if_id),
        .wb        (wb),
        .id_ex     (id_ex)
    );

    hazard_unit i_hazard (
        .if_id  (if_id),
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .wb     (wb),
        .stall  (stall),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage i_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (id_ex),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .mem_fwd   (ex_mem.alu_result),   // result one stage ahead
        .wb        (wb),
        .ex_mem    (ex_mem)
    );

    mem_wb_stage #(.DMEM_DEPTH(DMEM_DEPTH)) i_mem_wb (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .wb        (wb)
    );

    assign retire = wb;

endmodule

`default_nettype wire

/* src/decode_stage.sv */
// unknown opcodes and functions decode to nops with all control low
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               stall,
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::wb_event_t wb,
    output cpu_pkg::id_ex_t    id_ex
);

    cpu_pkg::opcode_e               opcode;
    cpu_pkg::funct_e                funct;
    cpu_pkg::ctrl_t                 ctrl;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs;
    logic [cpu_pkg::REG_ADDR_W-1:0] rt;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd_dst;
    logic [cpu_pkg::XLEN-1:0]       rs_val;
    logic [cpu_pkg::XLEN-1:0]       rt_val;
    logic [cpu_pkg::XLEN-1:0]       imm;

    assign opcode = cpu_pkg::opcode_e'(if_id.instr[31:26]);
    assign funct  = cpu_pkg::funct_e'(if_id.instr[5:0]);
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign imm    = {{(cpu_pkg::XLEN-16){if_id.instr[15]}}, if_id.instr[15:0]};

    reg_file i_reg_file (
        .SYS_clk (SYS_clk),
        .rs      (rs),
        .rt      (rt),
        .wb      (wb),
        .rs_val  (rs_val),
        .rt_val  (rt_val)
    );

    always_comb
    begin
        ctrl   = '0;
        rd_dst = '0;
        case (opcode)
            cpu_pkg::OP_RTYPE:
            begin
                rd_dst         = if_id.instr[15:11];
                ctrl.reg_write = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default:         ctrl.reg_write = 1'b0;   // also the all-zero word
                endcase
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LW:
            begin
                rd_dst           = rt;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = (opcode == cpu_pkg::OP_LW);
                ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;   // address = rs + imm
            end
            default: ctrl = '0;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            id_ex <= '0;   // bubble
        end
        else
        begin
            id_ex.ctrl   <= ctrl;
            id_ex.rs     <= rs;
            id_ex.rt     <= rt;
            id_ex.rd_dst <= rd_dst;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= rt_val;
            id_ex.imm    <= imm;
        end
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// slt compares signed; store data is the forwarded rt value
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  cpu_pkg::id_ex_t          id_ex,
    input  cpu_pkg::fwd_sel_e        fwd_a,
    input  cpu_pkg::fwd_sel_e        fwd_b,
    input  logic [cpu_pkg::XLEN-1:0] mem_fwd,
    input  cpu_pkg::wb_event_t       wb,
    output cpu_pkg::ex_mem_t         ex_mem
);

    logic [cpu_pkg::XLEN-1:0] op_a;
    logic [cpu_pkg::XLEN-1:0] rt_fwd;
    logic [cpu_pkg::XLEN-1:0] alu_b;
    logic [cpu_pkg::XLEN-1:0] alu_result;

    function automatic logic [cpu_pkg::XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_e        sel,
        input logic [cpu_pkg::XLEN-1:0] reg_val,
        input logic [cpu_pkg::XLEN-1:0] mem_val,
        input logic [cpu_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_mux(fwd_a, id_ex.rs_val, mem_fwd, wb.data);
    assign rt_fwd = fwd_mux(fwd_b, id_ex.rt_val, mem_fwd, wb.data);
    assign alu_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_fwd;

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ALU_SUB: alu_result = op_a - alu_b;
            cpu_pkg::ALU_AND: alu_result = op_a & alu_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | alu_b;
            cpu_pkg::ALU_SLT:
            begin
                alu_result = {{(cpu_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(alu_b))};
            end
            default:          alu_result = op_a + alu_b;   // add, addi, address calc
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_mem <= '0;
        end
        else
        begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd_dst     <= id_ex.rd_dst;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rt_fwd;
        end
    end

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// instruction memory is written only while run is low, index taken modulo IMEM_DEPTH
// pc is a word aligned byte address and wraps after IMEM_DEPTH words
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                run,
    input  logic                stall,
    input  cpu_pkg::prog_load_t prog,
    output cpu_pkg::if_id_t     if_id
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    logic [cpu_pkg::XLEN-1:0] imem [IMEM_DEPTH];
    logic [cpu_pkg::XLEN-1:0] pc;
    logic [IMEM_AW-1:0]       fetch_idx;
    logic [IMEM_AW-1:0]       load_idx;
    logic                     pc_last;

    assign fetch_idx = IMEM_AW'(pc >> 2);
    assign load_idx  = IMEM_AW'(prog.addr % IMEM_DEPTH);
    assign pc_last   = (fetch_idx == IMEM_AW'(IMEM_DEPTH - 1));

    always_ff @(posedge SYS_clk)
    begin
        if (prog.valid && !run)
        begin
            imem[load_idx] <= prog.word;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run)
        begin
            pc    <= '0;
            if_id <= '0;   // bubble
        end
        else if (!stall)   // stall holds pc and if_id
        begin
            pc          <= pc_last ? '0 : pc + 'd4;
            if_id.instr <= imem[fetch_idx];
        end
    end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
// purely combinational; a load is never forwarded from ex_mem since the stall moves it to wb
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::wb_event_t wb,
    output logic               stall,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b
);

    logic load_in_ex;

    function automatic cpu_pkg::fwd_sel_e fwd_source(
        input logic [cpu_pkg::REG_ADDR_W-1:0] src,
        input cpu_pkg::ex_mem_t               mem_stage,
        input cpu_pkg::wb_event_t             wb_stage
    );
        if (mem_stage.ctrl.reg_write && mem_stage.rd_dst != '0 && mem_stage.rd_dst == src)
        begin
            return cpu_pkg::FWD_MEM;   // youngest producer first
        end
        else if (wb_stage.valid && wb_stage.rd == src)
        begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    assign load_in_ex = id_ex.ctrl.mem_read && (id_ex.rd_dst != '0);

    // rt compared even when the consumer only writes it, costs a spare cycle at most
    assign stall = load_in_ex
                && (id_ex.rd_dst == if_id.instr[25:21] || id_ex.rd_dst == if_id.instr[20:16]);

    assign fwd_a = fwd_source(id_ex.rs, ex_mem, wb);
    assign fwd_b = fwd_source(id_ex.rt, ex_mem, wb);

endmodule

`default_nettype wire

/* src/mem_wb_stage.sv */
// data memory is word indexed by address/4 modulo DMEM_DEPTH, DMEM_DEPTH at least 2
// reads are combinational, writes land at the clock edge; contents start unknown
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::ex_mem_t   ex_mem,
    output cpu_pkg::wb_event_t wb
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [cpu_pkg::XLEN-1:0] dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]       word_idx;
    logic [cpu_pkg::XLEN-1:0] load_data;
    logic [cpu_pkg::XLEN-1:0] wb_data;

    assign word_idx  = DMEM_AW'((ex_mem.alu_result >> 2) % DMEM_DEPTH);
    assign load_data = dmem[word_idx];
    assign wb_data   = ex_mem.ctrl.mem_read ? load_data : ex_mem.alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.ctrl.mem_write)
        begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb <= '0;
        end
        else
        begin
            wb.valid <= ex_mem.ctrl.reg_write && (ex_mem.rd_dst != '0);   // r0 writes dropped
            wb.rd    <= ex_mem.rd_dst;
            wb.data  <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
// 32 entries, r0 reads as zero, a read of the register being written returns the new value
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                           SYS_clk,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rt,
    input  cpu_pkg::wb_event_t             wb,
    output logic [cpu_pkg::XLEN-1:0]       rs_val,
    output logic [cpu_pkg::XLEN-1:0]       rt_val
);

    logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::REG_ADDR_W];

    always_ff @(posedge SYS_clk)
    begin
        if (wb.valid && wb.rd != '0)
        begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-first bypass covers the distance-3 consumer
    assign rs_val = (rs == '0) ? '0 : (wb.valid && wb.rd == rs) ? wb.data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wb.valid && wb.rd == rt) ? wb.data : regs[rt];

endmodule

`default_nettype wire

/* tests/tb_cpu_model.svh */
// sequential reference model and the test program, included inside tb_cpu
// needs IMEM_DEPTH, DMEM_DEPTH, seed and expected_q declared before the include
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

logic [31:0] prog_mem [IMEM_DEPTH];
int          prog_len;
logic [31:0] model_regs [32];
logic [31:0] model_dmem [DMEM_DEPTH];

function automatic logic [31:0] enc_r(
    input cpu_pkg::funct_e fn,
    input int              rd,
    input int              rs,
    input int              rt
);
    return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
endfunction

function automatic logic [31:0] enc_i(
    input cpu_pkg::opcode_e op,
    input int               rt,
    input int               rs,
    input logic [15:0]      imm
);
    return {6'(op), 5'(rs), 5'(rt), imm};
endfunction

task automatic build_program;
    logic [15:0] imm [6];
    for (int i = 0; i < 6; i++)
    begin
        imm[i] = 16'($random(seed));
    end
    imm[0][15] = 1'b0;   // r1 positive so slt r10 depends on the sign
    imm[2][15] = 1'b1;   // negative operands for slt
    imm[3][15] = 1'b1;
    prog_mem[0]  = enc_i(cpu_pkg::OP_ADDI, 1, 0, imm[0]);
    prog_mem[1]  = enc_i(cpu_pkg::OP_ADDI, 2, 0, imm[1]);
    prog_mem[2]  = enc_i(cpu_pkg::OP_ADDI, 3, 0, imm[2]);
    prog_mem[3]  = enc_i(cpu_pkg::OP_ADDI, 4, 0, imm[3]);
    prog_mem[4]  = enc_r(cpu_pkg::FN_ADD, 5, 1, 2);
    prog_mem[5]  = enc_r(cpu_pkg::FN_SUB, 6, 3, 1);
    prog_mem[6]  = enc_r(cpu_pkg::FN_AND, 7, 1, 4);
    prog_mem[7]  = enc_r(cpu_pkg::FN_OR, 8, 2, 3);
    prog_mem[8]  = enc_r(cpu_pkg::FN_SLT, 9, 3, 4);
    prog_mem[9]  = enc_r(cpu_pkg::FN_SLT, 10, 4, 1);
    prog_mem[10] = enc_i(cpu_pkg::OP_ADDI, 12, 1, imm[4]);
    prog_mem[11] = enc_r(cpu_pkg::FN_SUB, 13, 12, 2);   // distance 1
    prog_mem[12] = enc_r(cpu_pkg::FN_AND, 14, 12, 13);  // distance 2 and 1
    prog_mem[13] = enc_r(cpu_pkg::FN_OR, 15, 12, 14);   // distance 3 on r12
    prog_mem[14] = enc_i(cpu_pkg::OP_SW, 15, 0, 16'd8);
    prog_mem[15] = enc_i(cpu_pkg::OP_LW, 16, 0, 16'd8);
    prog_mem[16] = enc_r(cpu_pkg::FN_ADD, 17, 16, 1);   // load-use
    prog_mem[17] = {6'h3f, 5'd1, 5'd18, 16'h1234};      // unknown opcode
    prog_mem[18] = enc_i(cpu_pkg::OP_ADDI, 0, 1, imm[5]);
    prog_mem[19] = enc_r(cpu_pkg::FN_ADD, 18, 0, 1);    // r0 written one ahead
    prog_mem[20] = enc_i(cpu_pkg::OP_SW, 6, 0, 16'd4);
    prog_mem[21] = enc_i(cpu_pkg::OP_LW, 19, 0, 16'd4);
    prog_mem[22] = enc_r(cpu_pkg::FN_SUB, 20, 19, 5);
    prog_mem[23] = enc_i(cpu_pkg::OP_LW, 21, 0, 16'd8);
    prog_mem[24] = enc_i(cpu_pkg::OP_SW, 21, 0, 16'd16);   // store data from a load
    prog_mem[25] = enc_i(cpu_pkg::OP_LW, 22, 0, 16'd16);
    prog_mem[26] = enc_r(cpu_pkg::FN_OR, 23, 22, 0);
    prog_len = 27;
    for (int i = prog_len; i < IMEM_DEPTH; i++)
    begin
        prog_mem[i] = {6'h3f, 2'b00, 8'(i), 8'(~i), 8'h00};   // unknown opcodes as filler
    end
endtask

task automatic run_model;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    int          dst;
    logic        wr;
    model_regs = '{default: '0};
    for (int i = 0; i < prog_len; i++)
    begin
        w   = prog_mem[i];
        a   = model_regs[w[25:21]];
        b   = model_regs[w[20:16]];
        imm = {{16{w[15]}}, w[15:0]};
        wr  = 1'b0;
        dst = w[20:16];
        res = '0;
        case (w[31:26])
            cpu_pkg::OP_RTYPE:
            begin
                wr  = 1'b1;
                dst = w[15:11];
                case (w[5:0])
                    cpu_pkg::FN_ADD: res = a + b;
                    cpu_pkg::FN_SUB: res = a - b;
                    cpu_pkg::FN_AND: res = a & b;
                    cpu_pkg::FN_OR:  res = a | b;
                    cpu_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         wr = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDI:
            begin
                wr  = 1'b1;
                res = a + imm;
            end
            cpu_pkg::OP_LW:
            begin
                wr  = 1'b1;
                res = model_dmem[((a + imm) >> 2) % DMEM_DEPTH];
            end
            cpu_pkg::OP_SW: model_dmem[((a + imm) >> 2) % DMEM_DEPTH] = b;
            default: ;   // unknown opcode is a nop
        endcase
        if (wr && dst != 0)
        begin
            model_regs[dst] = res;
            expected_q.push_back('{valid: 1'b1, rd: 5'(dst), data: res});
        end
    end
endtask

`endif

/* tests/tb_cpu.sv */
// loads one program through prog, runs it and checks every retire against a sequential model
// inputs change on the rising edge, retire is sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int IMEM_DEPTH    = 64;
    localparam int DMEM_DEPTH    = 64;
    localparam int DRAIN_TIMEOUT = 200;   // cycles

    logic                SYS_clk = 1'b0;
    logic                SYS_reset;
    logic                run;
    cpu_pkg::prog_load_t prog;
    cpu_pkg::wb_event_t  retire;

    integer             seed;
    cpu_pkg::wb_event_t expected_q [$];
    int                 expected_total;
    int                 retired      = 0;
    int                 mismatches   = 0;
    int                 unexpected   = 0;
    int                 idle_errors  = 0;
    int                 timeouts     = 0;
    int                 count_errors = 0;

    `include "tb_cpu_model.svh"

    cpu_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_dut (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .prog      (prog),
        .retire    (retire)
    );

    always #2 SYS_clk = ~SYS_clk;

    task automatic check_retire(input cpu_pkg::wb_event_t ev);
        cpu_pkg::wb_event_t exp;
        retired++;
        assert (expected_q.size() != 0)
        else
        begin
            unexpected++;
            $display("unexpected retire of r%0d at %0t ns, nothing left to expect", ev.rd, $time);
        end
        if (expected_q.size() != 0)
        begin
            exp = expected_q.pop_front();   // program order
            assert (ev.rd == exp.rd && ev.data == exp.data)
            else
            begin
                mismatches++;
                $display("Error at %0t ns: retire r%0d = %h, expected r%0d = %h",
                         $time, ev.rd, ev.data, exp.rd, exp.data);
            end
        end
    endtask

    task automatic load_program;
        for (int i = 0; i < IMEM_DEPTH; i++)
        begin
            @(posedge SYS_clk);
            prog.valid <= 1'b1;
            prog.addr  <= 8'(i);
            prog.word  <= prog_mem[i];
        end
        @(posedge SYS_clk);
        prog.valid <= 1'b0;
    endtask

    task automatic wait_queue_empty;
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT)
        begin
            @(posedge SYS_clk);
            cycles++;
        end
        if (expected_q.size() != 0)
        begin
            timeouts++;
            $display("timed out after %0d cycles with %0d retire events still missing",
                     DRAIN_TIMEOUT, expected_q.size());
        end
    endtask

    always @(negedge SYS_clk)
    begin
        if (!SYS_reset)
        begin
            assert (run || !retire.valid)
            else
            begin
                idle_errors++;
                $display("retire strobe seen at %0t ns while run is low", $time);
            end
            if (retire.valid)
            begin
                check_retire(retire);
            end
        end
    end

    initial
    begin
        int errors;
        SYS_reset = 1'b1;
        run       = 1'b0;
        prog      = '0;
        seed      = 32'h778e_fde7;
        build_program();
        run_model();
        expected_total = expected_q.size();
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        repeat (4) @(posedge SYS_clk);   // idle, run low
        load_program();
        @(posedge SYS_clk);
        run <= 1'b1;
        wait_queue_empty();
        repeat (10) @(posedge SYS_clk);   // room for late or duplicate strobes
        run <= 1'b0;
        @(posedge SYS_clk);
        assert (retired == expected_total)
        else
        begin
            count_errors++;
            $display("Error at %0t ns: %0d retire events, expected %0d",
                     $time, retired, expected_total);
        end
        errors = mismatches + unexpected + idle_errors + timeouts + count_errors;
        $display("retired %0d/%0d, mismatches %0d, unexpected %0d, idle %0d, timeouts %0d, count %0d",
                 retired, expected_total, mismatches, unexpected, idle_errors, timeouts,
                 count_errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
